// ==== build.sh ====
#!/usr/bin/env bash
# build the spi led testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f spiLed.f --top-module spiLedTb -o spiLedSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

simOutput=$(./obj_dir/spiLedSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== rtl/ledPkg.sv ====
// led register map package with addresses, reset values and blink counter sizing
package ledPkg;

  // register address and data widths
  localparam int regAddrBits = 2;
  localparam int regDataBits = 8;

  // register map
  localparam logic [regAddrBits-1:0] addrLedCtrl   = 2'd0;
  localparam logic [regAddrBits-1:0] addrBlinkRate = 2'd1;
  localparam logic [regAddrBits-1:0] addrScratch   = 2'd2;
  localparam logic [regAddrBits-1:0] addrChipId    = 2'd3;

  // read-only id, writes to its address are dropped
  localparam logic [regDataBits-1:0] chipIdValue = 8'hA5;

  // reset values of the writable registers
  localparam logic [regDataBits-1:0] ledCtrlReset   = 8'h00;
  localparam logic [regDataBits-1:0] blinkRateReset = 8'h00;
  localparam logic [regDataBits-1:0] scratchReset   = 8'h00;

  // free-running blink counter and the tap select width
  localparam int blinkCntBits = 16;
  localparam int rateBits = $clog2(blinkCntBits);

  // led 0 blinks, leds 4:1 follow ledCtrl
  localparam int ledCount = 5;

endpackage

// ==== rtl/ledRegs.sv ====
// led register bank with read mux, fixed chip id, blink counter and led output drive
`timescale 1ns/1ns

module ledRegs import ledPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [regAddrBits-1:0] regAddr,
  input  logic [regDataBits-1:0] regWrData,
  input  logic                   regWrEn,
  output logic [regDataBits-1:0] regRdData,
  output logic [ledCount-1:0]    ledOut
);

  // writable registers
  logic [regDataBits-1:0] ledCtrl;
  logic [regDataBits-1:0] blinkRate;
  logic [regDataBits-1:0] scratch;

  // free-running, wraps
  logic [blinkCntBits-1:0] blinkCnt;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      ledCtrl   <= ledCtrlReset;
      blinkRate <= blinkRateReset;
      scratch   <= scratchReset;
    end
    else if (regWrEn)
    begin
      case (regAddr)
        addrLedCtrl:   ledCtrl   <= regWrData;
        addrBlinkRate: blinkRate <= regWrData;
        addrScratch:   scratch   <= regWrData;
        // chip id is read-only, write dropped
        default:       ledCtrl   <= ledCtrl;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      blinkCnt <= '0;
    else
      blinkCnt <= blinkCnt + 1'b1;
  end

  // read mux, combinational so control can reload tx the next cycle
  always_comb
  begin
    regRdData = '0;
    case (regAddr)
      addrLedCtrl:   regRdData = ledCtrl;
      addrBlinkRate: regRdData = blinkRate;
      addrScratch:   regRdData = scratch;
      addrChipId:    regRdData = chipIdValue;
      default:       regRdData = '0;
    endcase
  end

  // counter tap k toggles every 2^k clk
  // so led 0 gives equal high and low runs of 2^rate
  assign ledOut[0] = blinkCnt[blinkRate[rateBits-1:0]];

  // upper leds straight from ledCtrl low bits
  assign ledOut[ledCount-1:1] = ledCtrl[ledCount-2:0];

endmodule

// ==== rtl/spiCtrl.sv ====
// spi frame controller that decodes the command, sequences register access and counts frames
`timescale 1ns/1ns

module spiCtrl import spiPkg::*, ledPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  spiEventIf.ctrl                ev,
  input  logic [byteBits-1:0]    rxByte,
  input  logic                   byteDone,
  output logic [byteBits-1:0]    txByte,
  output logic                   txLoad,
  output logic [regAddrBits-1:0] regAddr,
  output logic [regDataBits-1:0] regWrData,
  output logic                   regWrEn,
  input  logic [regDataBits-1:0] regRdData
);

  frameStateT frameState;

  // latched command fields
  logic                   isRead;
  logic [regAddrBits-1:0] addrQ;

  // frames that reached donePhase before select dropped, wraps at 256
  logic [byteBits-1:0] frameCnt;

  // reload strobes, one cycle after a byte completes
  logic loadData;
  logic loadZero;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      frameState <= idle;
      isRead     <= 1'b0;
      addrQ      <= '0;
      frameCnt   <= '0;
      loadData   <= 1'b0;
      loadZero   <= 1'b0;
    end
    else
    begin
      // command byte done, address is latched this edge
      // so read data is valid on the next cycle
      loadData <= byteDone && (frameState == cmdPhase);
      // after the data byte only zeros go out
      loadZero <= byteDone && (frameState == dataPhase);

      if (!ev.selActive)
      begin
        // only a full two-byte frame is counted
        // aborted frames just fall back to idle
        if (frameState == donePhase)
          frameCnt <= frameCnt + 1'b1;
        frameState <= idle;
      end
      else
      begin
        case (frameState)
          idle:
            if (ev.frameStart)
              frameState <= cmdPhase;
          cmdPhase:
            if (byteDone)
            begin
              isRead     <= rxByte[cmdReadBit];
              addrQ      <= rxByte[regAddrBits-1:0];
              frameState <= dataPhase;
            end
          dataPhase:
            if (byteDone)
              frameState <= donePhase;
          // extra bytes are ignored until select drops
          donePhase:
            frameState <= donePhase;
          default:
            frameState <= idle;
        endcase
      end
    end
  end

  // register side
  // write strobe lines up with the data byte so it lands one clk later
  assign regAddr   = addrQ;
  assign regWrData = rxByte;
  assign regWrEn   = byteDone && (frameState == dataPhase) && !isRead;

  // transmit reloads
  // frame count at frame start, then read data or zero for a write
  assign txLoad = ev.frameStart || loadData || loadZero;

  always_comb
  begin
    if (ev.frameStart)
      txByte = frameCnt;
    else if (loadData && isRead)
      txByte = regRdData;
    else
      txByte = '0;
  end

endmodule

// ==== rtl/spiEventIf.sv ====
// spi event bundle carrying synchronized strobes from the synchronizer to shifter and control
`timescale 1ns/1ns

interface spiEventIf;

  // one-cycle pulses from the sck edge detect
  logic sckRise;
  logic sckFall;

  // select level, high while ssel pin is low
  logic selActive;

  // one-cycle pulse on ssel falling
  logic frameStart;

  // synchronized mosi, sampled by the shifter on sckRise
  logic mosiBit;

  // synchronizer side drives everything
  modport source (output sckRise, output sckFall, output selActive,
                  output frameStart, output mosiBit);

  // shifter needs the bit clock edges and data
  modport shift (input sckRise, input sckFall, input selActive, input mosiBit);

  // control only follows the frame boundaries
  modport ctrl (input selActive, input frameStart);

endinterface

// ==== rtl/spiLedTop.sv ====
// spi led peripheral top joining synchronizer, shifter, frame control and register bank
`timescale 1ns/1ns

module spiLedTop import spiPkg::*, ledPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                sck,
  input  logic                ssel,
  input  logic                mosi,
  output logic                miso,
  output logic [ledCount-1:0] ledOut
);

  // synchronized spi strobes
  spiEventIf ev ();

  // shifter and control byte path
  logic [byteBits-1:0] rxByte;
  logic [byteBits-1:0] txByte;
  logic                byteDone;
  logic                txLoad;

  // register access
  logic [regAddrBits-1:0] regAddr;
  logic [regDataBits-1:0] regWrData;
  logic [regDataBits-1:0] regRdData;
  logic                   regWrEn;

  spiSync spiSync_i (
    .clk  (clk),
    .rstN (rstN),
    .sck  (sck),
    .ssel (ssel),
    .mosi (mosi),
    .ev   (ev.source)
  );

  spiShifter spiShifter_i (
    .clk      (clk),
    .rstN     (rstN),
    .ev       (ev.shift),
    .txByte   (txByte),
    .txLoad   (txLoad),
    .rxByte   (rxByte),
    .byteDone (byteDone),
    .miso     (miso)
  );

  spiCtrl spiCtrl_i (
    .clk       (clk),
    .rstN      (rstN),
    .ev        (ev.ctrl),
    .rxByte    (rxByte),
    .byteDone  (byteDone),
    .txByte    (txByte),
    .txLoad    (txLoad),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .regWrEn   (regWrEn),
    .regRdData (regRdData)
  );

  ledRegs ledRegs_i (
    .clk       (clk),
    .rstN      (rstN),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .regWrEn   (regWrEn),
    .regRdData (regRdData),
    .ledOut    (ledOut)
  );

endmodule

// ==== rtl/spiPkg.sv ====
// spi framing package with byte geometry, synchronizer depth and frame states
package spiPkg;

  // bits in one spi byte, shifted msb first
  localparam int byteBits = 8;

  // width of the bit counter inside a byte
  localparam int bitCntBits = $clog2(byteBits);

  // depth of the sck and ssel synchronizers
  // the two oldest stages feed the edge compare
  localparam int syncStages = 3;

  // mosi only needs metastability cover, no edge detect
  localparam int mosiStages = 2;

  // read flag position in the command byte
  // set means read, clear means write
  localparam int cmdReadBit = 7;

  // frame sequence
  // idle waits for ssel low, cmdPhase takes the command byte,
  // dataPhase moves the register byte, donePhase ignores extra bytes
  typedef enum logic [1:0] {
    idle,
    cmdPhase,
    dataPhase,
    donePhase
  } frameStateT;

endpackage

// ==== rtl/spiShifter.sv ====
// spi byte shifter with receive and transmit registers, bit counter and byte-done strobe
`timescale 1ns/1ns

module spiShifter import spiPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  spiEventIf.shift            ev,
  input  logic [byteBits-1:0] txByte,
  input  logic                txLoad,
  output logic [byteBits-1:0] rxByte,
  output logic                byteDone,
  output logic                miso
);

  // counts sck rising edges within the current byte
  logic [bitCntBits-1:0] bitCnt;

  // outgoing byte with its msb on the pin
  logic [byteBits-1:0] txReg;

  // last bit of a byte is on this rising edge
  logic lastBit;

  assign lastBit = (bitCnt == bitCntBits'(byteBits - 1));

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      bitCnt   <= '0;
      byteDone <= 1'b0;
    end
    else
    begin
      // a dropped select restarts byte alignment
      if (!ev.selActive)
        bitCnt <= '0;
      else if (ev.sckRise)
        bitCnt <= bitCnt + 1'b1;
      byteDone <= ev.selActive && ev.sckRise && lastBit;
    end
  end

  // receive side shifts left for msb first
  always_ff @(posedge clk)
  begin
    if (ev.selActive && ev.sckRise)
      rxByte <= {rxByte[byteBits-2:0], ev.mosiBit};
  end

  // transmit side
  // the falling edge right after a byte boundary (bitCnt wrapped to 0)
  // must not shift, or the msb of the next loaded byte is lost
  always_ff @(posedge clk)
  begin
    if (!rstN)
      txReg <= '0;
    else if (txLoad)
      txReg <= txByte;
    else if (ev.selActive && ev.sckFall && (bitCnt != '0))
      txReg <= {txReg[byteBits-2:0], 1'b0};
  end

  // single slave so miso is never tri-stated
  assign miso = txReg[byteBits-1];

endmodule

// ==== rtl/spiSync.sv ====
// spi pin synchronizer that turns sck, ssel and mosi into clk-domain edge and frame strobes
`timescale 1ns/1ns

module spiSync import spiPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     sck,
  input  logic     ssel,
  input  logic     mosi,
  spiEventIf.source ev
);

  // newest sample enters at bit 0
  logic [syncStages-1:0] sckReg;
  logic [syncStages-1:0] sselReg;
  logic [mosiStages-1:0] mosiReg;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      // idle bus levels, mode 0 sck low and ssel high
      // so no edge or frame start fires out of reset
      sckReg  <= '0;
      sselReg <= '1;
      mosiReg <= '0;
    end
    else
    begin
      sckReg  <= {sckReg[syncStages-2:0], sck};
      sselReg <= {sselReg[syncStages-2:0], ssel};
      mosiReg <= {mosiReg[mosiStages-2:0], mosi};
    end
  end

  // edges from the two oldest stages
  assign ev.sckRise = (sckReg[syncStages-1 -: 2] == 2'b01);
  assign ev.sckFall = (sckReg[syncStages-1 -: 2] == 2'b10);

  // ssel is active low
  // select level taken from the same stage that starts the frame
  assign ev.selActive  = ~sselReg[syncStages-2];
  assign ev.frameStart = (sselReg[syncStages-1 -: 2] == 2'b10);

  assign ev.mosiBit = mosiReg[mosiStages-1];

endmodule

// ==== spiLed.f ====
rtl/spiPkg.sv
rtl/ledPkg.sv
rtl/spiEventIf.sv
rtl/spiSync.sv
rtl/spiShifter.sv
rtl/spiCtrl.sv
rtl/ledRegs.sv
rtl/spiLedTop.sv
testbench/spiLedSva.sv
testbench/spiLedTb.sv

// ==== testbench/spiLedSva.sv ====
// concurrent checks on byte framing, register writes and transmit reloads in the spi led top
`timescale 1ns/1ns

module spiLedSva import spiPkg::*;
(
  input logic       clk,
  input logic       rstN,
  input logic       selActive,
  input logic       sckFall,
  input logic       byteDone,
  input logic       txLoad,
  input logic       regWrEn,
  input frameStateT frameState
);

  // a byte only completes inside a selected frame
  byteDoneInFrame: assert property (@(posedge clk) disable iff (!rstN)
    byteDone |-> selActive)
    else $error("byteDone pulsed while select was inactive");

  // the register write closes the data byte
  // control has moved on to donePhase one clk later
  writeEndsData: assert property (@(posedge clk) disable iff (!rstN)
    regWrEn |=> (frameState == donePhase))
    else $error("regWrEn was not followed by donePhase");

  // a transmit reload never meets an sck falling edge
  // load wins over shift there and one miso bit would be lost
  loadApartFromShift: assert property (@(posedge clk) disable iff (!rstN)
    txLoad |-> !sckFall)
    else $error("txLoad landed in the same cycle as sckFall");

endmodule

bind spiLedTop spiLedSva spiLedSva_i (
  .clk        (clk),
  .rstN       (rstN),
  .selActive  (ev.selActive),
  .sckFall    (ev.sckFall),
  .byteDone   (byteDone),
  .txLoad     (txLoad),
  .regWrEn    (regWrEn),
  .frameState (spiCtrl_i.frameState)
);

// ==== testbench/spiLedTb.sv ====
// testbench for the spi led peripheral, runs register frames from a table and checks leds
`timescale 1ns/1ns

module spiLedTb import ledPkg::*;
();

  localparam int clkPeriod = 100;
  // sck half period and idle gap after ssel rises, both in clk
  localparam int halfClk = 4;
  localparam int gapClk = 8;
  localparam int tableLen = 14;
  // 20 spi clocks of 8 clk per frame, plus slack for reset and blink check
  localparam int watchdogClks = tableLen * 20 * 8 + 2000;

  typedef enum logic [1:0] {opWrite, opRead, opAbort} opT;

  // one frame, expData is the byte miso returns during the data byte
  typedef struct packed {
    opT         op;
    logic [1:0] addr;
    logic [7:0] data;
    logic [7:0] expData;
  } stepT;

  logic                clk;
  logic                rstN;
  logic                sck;
  logic                ssel;
  logic                mosi;
  logic                miso;
  logic [ledCount-1:0] ledOut;

  stepT        steps [tableLen];
  logic [31:0] lfsrState;
  // completed frames so far and the led nibble last written
  logic [7:0]  frameCount;
  logic [3:0]  ledNibble;

  spiLedTop spiLedTop_i (
    .clk    (clk),
    .rstN   (rstN),
    .sck    (sck),
    .ssel   (ssel),
    .mosi   (mosi),
    .miso   (miso),
    .ledOut (ledOut)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic randByte(output logic [7:0] value);
    int k;
    value = '0;
    for (k = 0; k < 8; k++)
    begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[6:0], lfsrState[0]};
    end
  endtask

  task automatic reportFail(input string msg);
    $display("FAIL t=%0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic fillTable();
    logic [7:0] ledA;
    logic [7:0] ledB;
    logic [7:0] scratchVal;
    logic [7:0] rateVal;
    randByte(ledA);
    randByte(scratchVal);
    randByte(rateVal);
    randByte(ledB);
    // chip id first, frame count still 0
    steps[0]  = '{opRead,  addrChipId,    8'h00,       8'hA5};
    steps[1]  = '{opWrite, addrLedCtrl,   ledA,        8'h00};
    steps[2]  = '{opWrite, addrScratch,   scratchVal,  8'h00};
    steps[3]  = '{opRead,  addrScratch,   8'h00,       scratchVal};
    // aborted write must leave scratch alone and not count
    steps[4]  = '{opAbort, addrScratch,   ~scratchVal, 8'h00};
    steps[5]  = '{opRead,  addrScratch,   8'h00,       scratchVal};
    steps[6]  = '{opWrite, addrBlinkRate, rateVal,     8'h00};
    steps[7]  = '{opRead,  addrBlinkRate, 8'h00,       rateVal};
    // id is read-only
    steps[8]  = '{opWrite, addrChipId,    8'h3C,       8'h00};
    steps[9]  = '{opRead,  addrChipId,    8'h00,       8'hA5};
    steps[10] = '{opWrite, addrLedCtrl,   ledB,        8'h00};
    steps[11] = '{opRead,  addrLedCtrl,   8'h00,       ledB};
    steps[12] = '{opWrite, addrBlinkRate, 8'h03,       8'h00};
    steps[13] = '{opRead,  addrBlinkRate, 8'h00,       8'h03};
  endtask

  // mode 0 master, starts and ends on a falling clk edge
  task automatic spiFrame(input logic [15:0] txWord, input int nBits,
                          output logic [15:0] rxWord);
    int b;
    rxWord = '0;
    ssel = 1'b0;
    for (b = 0; b < nBits; b++)
    begin
      // mosi settles a half period before sck rises
      mosi = txWord[15-b];
      repeat (halfClk) @(negedge clk);
      rxWord[15-b] = miso;
      sck = 1'b1;
      repeat (halfClk) @(negedge clk);
      sck = 1'b0;
    end
    repeat (halfClk) @(negedge clk);
    ssel = 1'b1;
    mosi = 1'b0;
    repeat (gapClk) @(negedge clk);
  endtask

  // length in clk of the current level of led 0
  task automatic measureRun(output int runLen, output logic level);
    runLen = 0;
    level = ledOut[0];
    while (ledOut[0] == level && runLen < 64)
    begin
      @(negedge clk);
      runLen++;
    end
  endtask

  initial
  begin
    repeat (watchdogClks) @(posedge clk);
    $display("timeout: test sequence did not finish within %0d clk", watchdogClks);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    int         i;
    stepT       st;
    logic [7:0] cmd;
    logic [15:0] rxWord;
    int         runA;
    int         runB;
    logic       levelA;
    logic       levelB;

    // idle bus, sck low and ssel high
    rstN = 1'b0;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    lfsrState = 32'hea1c_08b1;
    frameCount = '0;
    ledNibble = '0;
    fillTable();

    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (ledOut == '0 && miso == 1'b0)
      else reportFail($sformatf("after reset ledOut=%b miso=%b, expected 0", ledOut, miso));
    rstN = 1'b1;
    repeat (gapClk) @(negedge clk);

    for (i = 0; i < tableLen; i++)
    begin
      st = steps[i];
      cmd = {st.op == opRead, 5'b00000, st.addr};
      if (st.op == opAbort)
      begin
        // select drops after four command bits
        spiFrame({cmd, st.data}, 4, rxWord);
        assert (rxWord[15:12] == frameCount[7:4])
          else reportFail($sformatf("step %0d aborted frame miso %h, expected %h",
                                    i, rxWord[15:12], frameCount[7:4]));
      end
      else
      begin
        spiFrame({cmd, st.data}, 16, rxWord);
        assert (rxWord[15:8] == frameCount)
          else reportFail($sformatf("step %0d frame count %h, expected %h",
                                    i, rxWord[15:8], frameCount));
        assert (rxWord[7:0] == st.expData)
          else reportFail($sformatf("step %0d data byte %h, expected %h",
                                    i, rxWord[7:0], st.expData));
        frameCount = frameCount + 8'd1;
        if (st.op == opWrite && st.addr == addrLedCtrl)
          ledNibble = st.data[3:0];
        assert (ledOut[ledCount-1:1] == ledNibble)
          else reportFail($sformatf("step %0d ledOut[4:1]=%h, expected %h",
                                    i, ledOut[ledCount-1:1], ledNibble));
      end
    end

    // rate 3 gives 8 clk high then 8 clk low
    // first run only lines up with an edge
    measureRun(runA, levelA);
    measureRun(runA, levelA);
    measureRun(runB, levelB);
    assert (runA == 8 && runB == 8 && levelA != levelB)
      else reportFail($sformatf("blink runs %0d and %0d clk, expected 8 and 8", runA, runB));

    $display("Simulation passed");
    $finish;
  end

endmodule
